/* hdl/dfi_seq_pkg.sv */
// DFI sequencer shared types, DDR3 command encodings and device timing constants
package dfi_seq_pkg;

    // ------------------------------------------------
    // Clock and device timing
    // ------------------------------------------------
    localparam int DDR_MHZ  = 50;
    localparam int CYCLE_NS = 1000 / DDR_MHZ;

    // ACTIVATE to READ/WRITE, rounded up to cycles
    localparam int T_RCD = (15 + CYCLE_NS - 1) / CYCLE_NS;
    // PRECHARGE to ACTIVATE
    localparam int T_RP  = (15 + CYCLE_NS - 1) / CYCLE_NS;
    // REFRESH to anything
    localparam int T_RFC = (260 + CYCLE_NS - 1) / CYCLE_NS;
    // Write to read turnaround, in cycles
    localparam int T_WTR = 6;

    // CAS latencies and burst
    localparam int WRITE_LATENCY = 6;
    localparam int READ_LATENCY  = 5;
    localparam int BURST_LEN     = 4;

    // DFI side latencies, one cycle lost in the command register
    localparam int PHY_WRLAT = WRITE_LATENCY - 1;
    localparam int PHY_RDLAT = READ_LATENCY - 1;

    // Spacing between column commands
    localparam int RW_NONSEQ = WRITE_LATENCY + BURST_LEN + T_WTR;
    // Same direction may follow back to back
    localparam int RW_SEQ    = RW_NONSEQ + 1 - BURST_LEN;

    // Spacing counter
    localparam int DELAY_W = 6;
    typedef logic [DELAY_W-1:0] delay_t;

    // Enable shift registers, latency plus burst
    localparam int WR_SHIFT_W = PHY_WRLAT + BURST_LEN;
    localparam int RD_SHIFT_W = PHY_RDLAT + BURST_LEN;

    // Write buffer
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // ------------------------------------------------
    // Bus widths
    // ------------------------------------------------
    localparam int ROW_W       = 15;
    localparam int BANK_W      = 3;
    localparam int LINE_W      = 128;
    localparam int MASK_W      = 16;
    localparam int BEAT_W      = LINE_W / BURST_LEN;
    localparam int BEAT_MASK_W = MASK_W / BURST_LEN;
    localparam int BEAT_IDX_W  = $clog2(BURST_LEN);

    // Bits are cs_n, ras_n, cas_n, we_n
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_ZQCL      = 4'b0110,
        CMD_NOP       = 4'b0111
    } cmd_e;

    // One command on the DFI pins, 22 bits
    typedef struct packed {
        cmd_e              cmd;
        logic [ROW_W-1:0]  addr;
        logic [BANK_W-1:0] bank;
    } dfi_cmd_t;

    // Write request, mask on top
    typedef struct packed {
        logic [MASK_W-1:0] mask;
        logic [LINE_W-1:0] data;
    } wr_line_t;

    // One DFI write beat
    typedef struct packed {
        logic [BEAT_W-1:0]      data;
        logic [BEAT_MASK_W-1:0] mask;
    } wr_beat_t;

    // Idle pin state
    localparam dfi_cmd_t DFI_CMD_IDLE = '{cmd: CMD_NOP, addr: '0, bank: '0};

endpackage

/* hdl/dfi_seq_ctrl.sv */
// DFI command control: spacing counter, accept logic, command pins and data enables
`timescale 1ns/1ps

module dfi_seq_ctrl
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  dfi_seq_pkg::dfi_cmd_t cmd_i,
    input  logic                  cke_i,
    output logic                  accept_o,
    output dfi_seq_pkg::dfi_cmd_t dfi_cmd_o,
    output logic                  dfi_cke_o,
    output logic                  wr_push_o,
    output logic                  wr_beat_en_o,
    output logic                  dfi_rddata_en_o
);

    dfi_seq_pkg::delay_t                        delay_q;
    dfi_seq_pkg::delay_t                        delay_d;
    int unsigned                                load_val;
    dfi_seq_pkg::cmd_e                          last_cmd_q;
    logic                                       is_nop;
    logic                                       is_read;
    logic                                       is_write;
    logic                                       rd_early;
    logic                                       wr_early;
    logic                                       take;
    logic [dfi_seq_pkg::WR_SHIFT_W-2:0]         wr_sh_q;
    logic [dfi_seq_pkg::RD_SHIFT_W-1:0]         rd_sh_q;
    dfi_seq_pkg::dfi_cmd_t                      dfi_cmd_q;
    logic                                       cke_q;

    // ------------------------------------------------
    // Acceptance
    // ------------------------------------------------
    assign is_nop   = (cmd_i.cmd == dfi_seq_pkg::CMD_NOP);
    assign is_read  = (cmd_i.cmd == dfi_seq_pkg::CMD_READ);
    assign is_write = (cmd_i.cmd == dfi_seq_pkg::CMD_WRITE);

    // Same direction column command once the burst has cleared
    assign rd_early = is_read && (last_cmd_q == dfi_seq_pkg::CMD_READ)
                      && (delay_q == dfi_seq_pkg::delay_t'(dfi_seq_pkg::RW_SEQ));
    assign wr_early = is_write && (last_cmd_q == dfi_seq_pkg::CMD_WRITE)
                      && (delay_q == dfi_seq_pkg::delay_t'(dfi_seq_pkg::RW_SEQ));

    assign accept_o = (delay_q == '0) || is_nop || rd_early || wr_early;

    // Real command taken this edge
    assign take      = accept_o && !is_nop;
    assign wr_push_o = take && is_write;

    // Last non-NOP command, for the early accept
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            last_cmd_q <= dfi_seq_pkg::CMD_NOP;
        else if (take)
            last_cmd_q <= cmd_i.cmd;
    end

    // ------------------------------------------------
    // Spacing counter
    // ------------------------------------------------
    always_comb
    begin
        // Hold-off owed to the presented command
        case (cmd_i.cmd)
            dfi_seq_pkg::CMD_ACTIVE:    load_val = dfi_seq_pkg::T_RCD;
            dfi_seq_pkg::CMD_READ,
            dfi_seq_pkg::CMD_WRITE:     load_val = dfi_seq_pkg::RW_NONSEQ;
            dfi_seq_pkg::CMD_PRECHARGE: load_val = dfi_seq_pkg::T_RP;
            dfi_seq_pkg::CMD_REFRESH:   load_val = dfi_seq_pkg::T_RFC;
            default:                    load_val = 0;
        endcase

        // Idle or early accept reloads, otherwise count down
        if (delay_q == '0 || rd_early || wr_early)
            delay_d = dfi_seq_pkg::delay_t'(load_val);
        else
            delay_d = delay_q - dfi_seq_pkg::delay_t'(1);
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            delay_q <= '0;
        else
            delay_q <= delay_d;
    end

    // ------------------------------------------------
    // Data enables
    // ------------------------------------------------
    // Burst of ones lands PHY_WRLAT - 1 shifts ahead of bit 0
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            wr_sh_q <= '0;
        else if (take && is_write)
            wr_sh_q <= {{dfi_seq_pkg::BURST_LEN{1'b1}}, wr_sh_q[dfi_seq_pkg::PHY_WRLAT-1:1]};
        else
            wr_sh_q <= {1'b0, wr_sh_q[dfi_seq_pkg::WR_SHIFT_W-2:1]};
    end

    // Serializer registers the beat, so the strobe is left raw
    assign wr_beat_en_o = wr_sh_q[0];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            rd_sh_q <= '0;
        else if (take && is_read)
            rd_sh_q <= {{dfi_seq_pkg::BURST_LEN{1'b1}}, rd_sh_q[dfi_seq_pkg::PHY_RDLAT:1]};
        else
            rd_sh_q <= {1'b0, rd_sh_q[dfi_seq_pkg::RD_SHIFT_W-1:1]};
    end

    // Read enable straight off the last stage
    assign dfi_rddata_en_o = rd_sh_q[0];

    // ------------------------------------------------
    // Pin registers
    // ------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            dfi_cmd_q   <= dfi_seq_pkg::DFI_CMD_IDLE;
            cke_q       <= 1'b0;
        end
        else
        begin
            // Zero address and bank when nothing is issued
            dfi_cmd_q   <= take ? cmd_i : dfi_seq_pkg::DFI_CMD_IDLE;
            cke_q       <= cke_i;
        end
    end

    assign dfi_cmd_o       = dfi_cmd_q;
    assign dfi_cke_o       = cke_q;

    // Spacing keeps a new write burst clear of the one in flight
    a_wr_no_overlap: assert property (@(posedge clk_i) disable iff (rst_i)
        (take && is_write)
        |-> (wr_sh_q[dfi_seq_pkg::WR_SHIFT_W-2:dfi_seq_pkg::PHY_WRLAT] == '0));

    // Same for read bursts
    a_rd_no_overlap: assert property (@(posedge clk_i) disable iff (rst_i)
        (take && is_read)
        |-> (rd_sh_q[dfi_seq_pkg::RD_SHIFT_W-1:dfi_seq_pkg::PHY_RDLAT+1] == '0));

endmodule

/* hdl/dfi_wr_fifo.sv */
// Write line buffer: circular FIFO of data and mask per accepted WRITE
`timescale 1ns/1ps

module dfi_wr_fifo
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  push_i,
    input  dfi_seq_pkg::wr_line_t data_i,
    input  logic                  pop_i,
    output dfi_seq_pkg::wr_line_t data_o
);

    dfi_seq_pkg::wr_line_t              mem [dfi_seq_pkg::FIFO_DEPTH];
    logic [dfi_seq_pkg::FIFO_AW-1:0]    wr_ptr_q;
    logic [dfi_seq_pkg::FIFO_AW-1:0]    rd_ptr_q;
    logic [dfi_seq_pkg::FIFO_AW:0]      count_q;

    // ------------------------------------------------
    // Storage
    // ------------------------------------------------
    // Entry written on the edge that takes the WRITE
    always_ff @(posedge clk_i)
    begin
        if (push_i)
            mem[wr_ptr_q] <= data_i;
    end

    // Head of queue, read combinationally
    assign data_o = mem[rd_ptr_q];

    // ------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            // Simultaneous push and pop leaves the count alone
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Command spacing must keep the buffer from filling
    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i |-> (count_q != (dfi_seq_pkg::FIFO_AW + 1)'(dfi_seq_pkg::FIFO_DEPTH) || pop_i));

    // Last beat only ever follows a pushed WRITE
    a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> (count_q != '0));

endmodule

/* hdl/dfi_wr_serializer.sv */
// Write beat serializer: slices the head line into registered DFI write beats
`timescale 1ns/1ps

module dfi_wr_serializer
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  beat_en_i,
    input  dfi_seq_pkg::wr_line_t line_i,
    output dfi_seq_pkg::wr_beat_t beat_o,
    output logic                  beat_valid_o,
    output logic                  pop_o
);

    logic [dfi_seq_pkg::BEAT_IDX_W-1:0] beat_idx_q;
    dfi_seq_pkg::wr_beat_t              beat_d;
    dfi_seq_pkg::wr_beat_t              beat_q;
    logic                               valid_q;
    logic                               last_beat;

    // ------------------------------------------------
    // Slice select
    // ------------------------------------------------
    // Lowest slice goes first
    always_comb
    begin
        beat_d.data = line_i.data[beat_idx_q * dfi_seq_pkg::BEAT_W +: dfi_seq_pkg::BEAT_W];
        beat_d.mask = line_i.mask[beat_idx_q * dfi_seq_pkg::BEAT_MASK_W
                                  +: dfi_seq_pkg::BEAT_MASK_W];
    end

    assign last_beat = (beat_idx_q == dfi_seq_pkg::BEAT_IDX_W'(dfi_seq_pkg::BURST_LEN - 1));

    // Line is done once its top slice is taken
    assign pop_o = beat_en_i && last_beat;

    // ------------------------------------------------
    // Beat register
    // ------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            beat_idx_q <= '0;
            beat_q     <= '0;
            valid_q    <= 1'b0;
        end
        else if (beat_en_i)
        begin
            beat_idx_q <= beat_idx_q + 1'b1;
            beat_q     <= beat_d;
            valid_q    <= 1'b1;
        end
        else
        begin
            // Bus is quiet between bursts
            beat_q  <= '0;
            valid_q <= 1'b0;
        end
    end

    assign beat_o       = beat_q;
    assign beat_valid_o = valid_q;

endmodule

/* hdl/dfi_rd_assembler.sv */
// Read word assembler: packs returned DFI read beats into one wide word
`timescale 1ns/1ps

module dfi_rd_assembler
(
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic [dfi_seq_pkg::BEAT_W-1:0]     beat_i,
    input  logic                               beat_valid_i,
    output logic [dfi_seq_pkg::LINE_W-1:0]     line_o,
    output logic                               line_valid_o
);

    logic [dfi_seq_pkg::LINE_W-1:0]     line_q;
    logic [dfi_seq_pkg::BEAT_IDX_W-1:0] beat_idx_q;
    logic                               valid_q;

    // ------------------------------------------------
    // Beat shift
    // ------------------------------------------------
    // New beat enters on top, first beat ends in the low slice
    always_ff @(posedge clk_i)
    begin
        if (beat_valid_i)
            line_q <= {beat_i, line_q[dfi_seq_pkg::LINE_W-1:dfi_seq_pkg::BEAT_W]};
    end

    // Beat count and word strobe
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            beat_idx_q <= '0;
            valid_q    <= 1'b0;
        end
        else
        begin
            if (beat_valid_i)
                beat_idx_q <= beat_idx_q + 1'b1;
            // One cycle pulse after the closing beat
            valid_q <= beat_valid_i
                       && (beat_idx_q == dfi_seq_pkg::BEAT_IDX_W'(dfi_seq_pkg::BURST_LEN - 1));
        end
    end

    assign line_o       = line_q;
    assign line_valid_o = valid_q;

endmodule

/* hdl/dfi_seq_top.sv */
// DDR3 DFI command sequencer top: control path with write and read datapaths
`timescale 1ns/1ps

module dfi_seq_top
(
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  dfi_seq_pkg::dfi_cmd_t              cmd_i,
    input  logic                               cke_i,
    input  dfi_seq_pkg::wr_line_t              wr_line_i,
    input  logic [dfi_seq_pkg::BEAT_W-1:0]     dfi_rddata_i,
    input  logic                               dfi_rddata_valid_i,
    output logic                               accept_o,
    output dfi_seq_pkg::dfi_cmd_t              dfi_cmd_o,
    output logic                               dfi_cke_o,
    output logic [dfi_seq_pkg::BEAT_W-1:0]     dfi_wrdata_o,
    output logic [dfi_seq_pkg::BEAT_MASK_W-1:0] dfi_wrdata_mask_o,
    output logic                               dfi_wrdata_en_o,
    output logic                               dfi_rddata_en_o,
    output logic [dfi_seq_pkg::LINE_W-1:0]     rddata_o,
    output logic                               rddata_valid_o
);

    logic                  wr_push;
    logic                  wr_pop;
    logic                  wr_beat_en;
    dfi_seq_pkg::wr_line_t wr_head;
    dfi_seq_pkg::wr_beat_t wr_beat;

    // ------------------------------------------------
    // Command control
    // ------------------------------------------------
    dfi_seq_ctrl dfi_seq_ctrl_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .cmd_i           (cmd_i),
        .cke_i           (cke_i),
        .accept_o        (accept_o),
        .dfi_cmd_o       (dfi_cmd_o),
        .dfi_cke_o       (dfi_cke_o),
        .wr_push_o       (wr_push),
        .wr_beat_en_o    (wr_beat_en),
        .dfi_rddata_en_o (dfi_rddata_en_o)
    );

    // ------------------------------------------------
    // Write path
    // ------------------------------------------------
    dfi_wr_fifo dfi_wr_fifo_i (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .push_i (wr_push),
        .data_i (wr_line_i),
        .pop_i  (wr_pop),
        .data_o (wr_head)
    );

    dfi_wr_serializer dfi_wr_serializer_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .beat_en_i    (wr_beat_en),
        .line_i       (wr_head),
        .beat_o       (wr_beat),
        .beat_valid_o (dfi_wrdata_en_o),
        .pop_o        (wr_pop)
    );

    // Beat fields onto the DFI pins
    assign dfi_wrdata_o      = wr_beat.data;
    assign dfi_wrdata_mask_o = wr_beat.mask;

    // Read path, no back-pressure to the PHY
    dfi_rd_assembler dfi_rd_assembler_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .beat_i       (dfi_rddata_i),
        .beat_valid_i (dfi_rddata_valid_i),
        .line_o       (rddata_o),
        .line_valid_o (rddata_valid_o)
    );

endmodule

/* sim/tb_dfi_checks.svh */
// Compare tasks for the DFI sequencer testbench, one per kind of result
`ifndef TB_DFI_CHECKS_SVH
`define TB_DFI_CHECKS_SVH

    // --------------------------------------------------
    // Command pins
    // --------------------------------------------------
    task automatic check_cmd(input string                 name,
                             input dfi_seq_pkg::dfi_cmd_t got,
                             input dfi_seq_pkg::dfi_cmd_t exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %s addr %h bank %h exp %s addr %h bank %h",
                     $time, name, got.cmd.name(), got.addr, got.bank,
                     exp.cmd.name(), exp.addr, exp.bank);
            stop_run_failed("command pins differ from the model");
        end
    endtask

    // --------------------------------------------------
    // Write beat, data and mask together
    // --------------------------------------------------
    task automatic check_beat(input string                 name,
                              input dfi_seq_pkg::wr_beat_t got,
                              input dfi_seq_pkg::wr_beat_t exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got data %h mask %h exp data %h mask %h",
                     $time, name, got.data, got.mask, exp.data, exp.mask);
            stop_run_failed("write beat differs from the model");
        end
    endtask

    // Single bit results: accept, clock enable, data enables, word strobe
    task automatic check_flag(input string name,
                              input logic  got,
                              input logic  exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
            stop_run_failed("control flag differs from the model");
        end
    endtask

    // --------------------------------------------------
    // Assembled read word
    // --------------------------------------------------
    task automatic check_word(input string                          name,
                              input logic [dfi_seq_pkg::LINE_W-1:0] got,
                              input logic [dfi_seq_pkg::LINE_W-1:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            stop_run_failed("read word differs from the model");
        end
    endtask

`endif

/* sim/tb_dfi_seq.sv */
// Testbench for the DFI command sequencer, random commands against a cycle model
`timescale 1ns/1ps

module tb_dfi_seq;

    localparam int NUM_CMDS        = 300;
    localparam int DRAIN_CYCLES    = 24;
    localparam int RING            = 32;
    // Data enables lag the command pins by the PHY latencies
    localparam int WR_OFF          = dfi_seq_pkg::PHY_WRLAT;
    localparam int RD_OFF          = dfi_seq_pkg::PHY_RDLAT;
    localparam int WATCHDOG_CYCLES = (NUM_CMDS + 2) * (dfi_seq_pkg::T_RFC + 10);

    logic                                   clk_i;
    logic                                   rst_i;
    dfi_seq_pkg::dfi_cmd_t                  cmd_i;
    logic                                   cke_i;
    dfi_seq_pkg::wr_line_t                  wr_line_i;
    logic [dfi_seq_pkg::BEAT_W-1:0]         dfi_rddata_i;
    logic                                   dfi_rddata_valid_i;
    logic                                   accept_o;
    dfi_seq_pkg::dfi_cmd_t                  dfi_cmd_o;
    logic                                   dfi_cke_o;
    logic [dfi_seq_pkg::BEAT_W-1:0]         dfi_wrdata_o;
    logic [dfi_seq_pkg::BEAT_MASK_W-1:0]    dfi_wrdata_mask_o;
    logic                                   dfi_wrdata_en_o;
    logic                                   dfi_rddata_en_o;
    logic [dfi_seq_pkg::LINE_W-1:0]         rddata_o;
    logic                                   rddata_valid_o;
    dfi_seq_pkg::wr_beat_t                  wr_beat_seen;

    // Expected results per cycle, ring indexed by cycle number
    dfi_seq_pkg::dfi_cmd_t                  exp_cmd        [RING];
    logic                                   exp_cke        [RING];
    dfi_seq_pkg::wr_beat_t                  exp_beat       [RING];
    logic                                   exp_wr_en      [RING];
    logic                                   exp_rd_en      [RING];
    logic                                   exp_word_valid [RING];
    logic [dfi_seq_pkg::LINE_W-1:0]         exp_word       [RING];
    // PHY return schedule
    logic                                   phy_valid      [RING];
    logic [dfi_seq_pkg::BEAT_W-1:0]         phy_beat       [RING];

    logic [31:0]                            rng_state;
    int                                     model_cnt;
    dfi_seq_pkg::cmd_e                      model_last;
    dfi_seq_pkg::dfi_cmd_t                  cur_cmd;
    dfi_seq_pkg::wr_line_t                  cur_line;
    logic                                   have_cmd;
    int                                     num_taken;
    int                                     cyc;

    assign wr_beat_seen = {dfi_wrdata_o, dfi_wrdata_mask_o};

    dfi_seq_top dfi_seq_top_i (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .cmd_i              (cmd_i),
        .cke_i              (cke_i),
        .wr_line_i          (wr_line_i),
        .dfi_rddata_i       (dfi_rddata_i),
        .dfi_rddata_valid_i (dfi_rddata_valid_i),
        .accept_o           (accept_o),
        .dfi_cmd_o          (dfi_cmd_o),
        .dfi_cke_o          (dfi_cke_o),
        .dfi_wrdata_o       (dfi_wrdata_o),
        .dfi_wrdata_mask_o  (dfi_wrdata_mask_o),
        .dfi_wrdata_en_o    (dfi_wrdata_en_o),
        .dfi_rddata_en_o    (dfi_rddata_en_o),
        .rddata_o           (rddata_o),
        .rddata_valid_o     (rddata_valid_o)
    );

    // 100 ns clock
    always #50 clk_i = ~clk_i;

    task automatic stop_run_failed(input string why);
        $display("Something failed");
        $fatal(1, "%s", why);
    endtask

    `include "tb_dfi_checks.svh"

    // --------------------------------------------------
    // Random source and stimulus
    // --------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Column commands weighted up so same direction pairs happen often
    function automatic dfi_seq_pkg::cmd_e pick_cmd(input logic [3:0] sel);
        case (sel)
            4'd0, 4'd1, 4'd2, 4'd3: return dfi_seq_pkg::CMD_READ;
            4'd4, 4'd5, 4'd6, 4'd7: return dfi_seq_pkg::CMD_WRITE;
            4'd8, 4'd9:             return dfi_seq_pkg::CMD_ACTIVE;
            4'd10:                  return dfi_seq_pkg::CMD_PRECHARGE;
            4'd11:                  return dfi_seq_pkg::CMD_REFRESH;
            4'd12:                  return dfi_seq_pkg::CMD_ZQCL;
            4'd13:                  return dfi_seq_pkg::CMD_LOAD_MODE;
            default:                return dfi_seq_pkg::CMD_NOP;
        endcase
    endfunction

    task automatic new_command();
        logic [31:0] r;
        r            = next_random();
        cur_cmd.cmd  = pick_cmd(r[3:0]);
        cur_cmd.addr = r[18:4];
        cur_cmd.bank = r[21:19];
        cur_line.data = {next_random(), next_random(), next_random(), next_random()};
        r             = next_random();
        cur_line.mask = r[15:0];
    endtask

    // Device hold-off owed after a command
    function automatic int holdoff_cycles(input dfi_seq_pkg::cmd_e cmd);
        case (cmd)
            dfi_seq_pkg::CMD_ACTIVE:    return dfi_seq_pkg::T_RCD;
            dfi_seq_pkg::CMD_READ:      return dfi_seq_pkg::RW_NONSEQ;
            dfi_seq_pkg::CMD_WRITE:     return dfi_seq_pkg::RW_NONSEQ;
            dfi_seq_pkg::CMD_PRECHARGE: return dfi_seq_pkg::T_RP;
            dfi_seq_pkg::CMD_REFRESH:   return dfi_seq_pkg::T_RFC;
            default:                    return 0;
        endcase
    endfunction

    task automatic clear_slot(input int s);
        exp_cmd[s]        = dfi_seq_pkg::DFI_CMD_IDLE;
        exp_cke[s]        = 1'b0;
        exp_beat[s]       = '0;
        exp_wr_en[s]      = 1'b0;
        exp_rd_en[s]      = 1'b0;
        exp_word_valid[s] = 1'b0;
        exp_word[s]       = '0;
    endtask

    // --------------------------------------------------
    // Per cycle check, drive and model update
    // --------------------------------------------------
    task automatic check_outputs(input int c);
        int s;
        s = c % RING;
        check_cmd("dfi_cmd_o", dfi_cmd_o, exp_cmd[s]);
        check_flag("dfi_cke_o", dfi_cke_o, exp_cke[s]);
        check_flag("dfi_wrdata_en_o", dfi_wrdata_en_o, exp_wr_en[s]);
        check_beat("dfi_wrdata_o/dfi_wrdata_mask_o", wr_beat_seen, exp_beat[s]);
        check_flag("dfi_rddata_en_o", dfi_rddata_en_o, exp_rd_en[s]);
        check_flag("rddata_valid_o", rddata_valid_o, exp_word_valid[s]);
        if (exp_word_valid[s])
            check_word("rddata_o", rddata_o, exp_word[s]);
        clear_slot(s);
    endtask

    task automatic drive_inputs(input int c);
        int          s;
        logic [31:0] r;
        s = c % RING;
        // Hold the current command until it is taken
        if (!have_cmd)
        begin
            if (num_taken < NUM_CMDS)
                new_command();
            else
                cur_cmd = dfi_seq_pkg::DFI_CMD_IDLE;
            have_cmd = 1'b1;
        end
        r                  = next_random();
        cmd_i              = cur_cmd;
        wr_line_i          = cur_line;
        cke_i              = r[31];
        // Junk data outside beats must be ignored
        dfi_rddata_valid_i = phy_valid[s];
        dfi_rddata_i       = phy_valid[s] ? phy_beat[s] : r;
        phy_valid[s]       = 1'b0;
    endtask

    task automatic model_step(input int c);
        int                             s;
        int                             k;
        int                             b;
        logic                           early;
        logic                           acc;
        logic [31:0]                    r;
        logic [dfi_seq_pkg::LINE_W-1:0] word;
        dfi_seq_pkg::cmd_e              cmd;
        cmd   = cur_cmd.cmd;
        s     = c + 1;
        word  = '0;
        early = (cmd == dfi_seq_pkg::CMD_READ || cmd == dfi_seq_pkg::CMD_WRITE)
                && (cmd == model_last) && (model_cnt == dfi_seq_pkg::RW_SEQ);
        acc   = (model_cnt == 0) || (cmd == dfi_seq_pkg::CMD_NOP) || early;
        check_flag("accept_o", accept_o, acc);
        exp_cke[s % RING] = cke_i;
        // Load on idle or early accept, otherwise count down
        if (model_cnt == 0 || early)
            model_cnt = holdoff_cycles(cmd);
        else
            model_cnt = model_cnt - 1;
        if (acc)
            have_cmd = 1'b0;
        if (acc && cmd != dfi_seq_pkg::CMD_NOP)
        begin
            num_taken++;
            model_last        = cmd;
            exp_cmd[s % RING] = cur_cmd;
            for (k = 0; k < dfi_seq_pkg::BURST_LEN; k++)
            begin
                if (cmd == dfi_seq_pkg::CMD_WRITE)
                begin
                    // Lowest slice first
                    b                 = (s + WR_OFF + k) % RING;
                    exp_wr_en[b]      = 1'b1;
                    exp_beat[b].data  = cur_line.data[k * dfi_seq_pkg::BEAT_W
                                                      +: dfi_seq_pkg::BEAT_W];
                    exp_beat[b].mask  = cur_line.mask[k * dfi_seq_pkg::BEAT_MASK_W
                                                      +: dfi_seq_pkg::BEAT_MASK_W];
                end
                else if (cmd == dfi_seq_pkg::CMD_READ)
                begin
                    r = next_random();
                    exp_rd_en[(s + RD_OFF + k) % RING] = 1'b1;
                    b            = (s + dfi_seq_pkg::READ_LATENCY + k) % RING;
                    phy_valid[b] = 1'b1;
                    phy_beat[b]  = r;
                    word[k * dfi_seq_pkg::BEAT_W +: dfi_seq_pkg::BEAT_W] = r;
                end
            end
            // Word strobe one cycle after the last returned beat
            if (cmd == dfi_seq_pkg::CMD_READ)
            begin
                b                 = (s + dfi_seq_pkg::READ_LATENCY + dfi_seq_pkg::BURST_LEN)
                                    % RING;
                exp_word_valid[b] = 1'b1;
                exp_word[b]       = word;
            end
        end
    endtask

    task automatic run_cycle(input int c);
        check_outputs(c);
        drive_inputs(c);
        // Let accept settle on the new inputs
        #1;
        model_step(c);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial
    begin
        int i;
        clk_i              = 1'b0;
        rst_i              = 1'b1;
        cmd_i              = dfi_seq_pkg::DFI_CMD_IDLE;
        cke_i              = 1'b0;
        wr_line_i          = '0;
        dfi_rddata_i       = '0;
        dfi_rddata_valid_i = 1'b0;
        rng_state          = 32'he1e4_f076;
        model_cnt          = 0;
        model_last         = dfi_seq_pkg::CMD_NOP;
        cur_cmd            = dfi_seq_pkg::DFI_CMD_IDLE;
        cur_line           = '0;
        have_cmd           = 1'b0;
        num_taken          = 0;
        for (i = 0; i < RING; i++)
        begin
            clear_slot(i);
            phy_valid[i] = 1'b0;
            phy_beat[i]  = '0;
        end

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        // All pins idle out of reset
        check_cmd("dfi_cmd_o", dfi_cmd_o, dfi_seq_pkg::DFI_CMD_IDLE);
        check_flag("dfi_cke_o", dfi_cke_o, 1'b0);
        check_flag("dfi_wrdata_en_o", dfi_wrdata_en_o, 1'b0);
        check_flag("dfi_rddata_en_o", dfi_rddata_en_o, 1'b0);
        check_flag("rddata_valid_o", rddata_valid_o, 1'b0);
        rst_i = 1'b0;

        cyc = 0;
        while (num_taken < NUM_CMDS)
        begin
            run_cycle(cyc);
            cyc++;
            @(negedge clk_i);
        end
        // Let the last bursts and read words come out
        repeat (DRAIN_CYCLES)
        begin
            run_cycle(cyc);
            cyc++;
            @(negedge clk_i);
        end
        $display("Everything OK");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        stop_run_failed($sformatf("timeout: run not done after %0d cycles, %0d commands taken",
                                  WATCHDOG_CYCLES, num_taken));
    end

endmodule

/* list.f */
+incdir+sim
hdl/dfi_seq_pkg.sv
hdl/dfi_seq_ctrl.sv
hdl/dfi_wr_fifo.sv
hdl/dfi_wr_serializer.sv
hdl/dfi_rd_assembler.sv
hdl/dfi_seq_top.sv
sim/tb_dfi_seq.sv

/* Makefile */
# Verilator build and run of the DFI sequencer testbench

TOP := tb_dfi_seq

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)

# Pass only when the pass line shows up in the output
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module dfi_seq_top

clean:
	rm -rf obj_dir
